// ==== design/wm_pkg.sv ====
// Bus widths, burst constants, width types, transfer-plan and request structs, W-channel states

package wm_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int XFER_WIDTH = 20;

  ////////////////////////////////////////////////////////////
  // Burst constants
  ////////////////////////////////////////////////////////////
  // Bursts stay inside a 4 KiB page and under 256 beats
  localparam int MAX_BURST_BEATS = (4096 / STRB_WIDTH < 256) ? 4096 / STRB_WIDTH : 256;
  localparam int BURST_BYTES     = MAX_BURST_BEATS * STRB_WIDTH;

  // Bit positions derived from the above
  localparam int LOG_STRB        = $clog2(STRB_WIDTH);
  localparam int LOG_BURST_BEATS = $clog2(MAX_BURST_BEATS);
  localparam int LOG_BURST_BYTES = $clog2(BURST_BYTES);
  localparam int BEAT_CNT_WIDTH  = XFER_WIDTH - LOG_STRB;
  localparam int BURST_CNT_WIDTH = BEAT_CNT_WIDTH - LOG_BURST_BEATS;

  ////////////////////////////////////////////////////////////
  // Width types
  ////////////////////////////////////////////////////////////
  typedef logic [ADDR_WIDTH-1:0]      addr_t;
  typedef logic [DATA_WIDTH-1:0]      data_t;
  typedef logic [STRB_WIDTH-1:0]      strb_t;
  typedef logic [XFER_WIDTH-1:0]      xfer_t;
  typedef logic [LOG_BURST_BEATS-1:0] beat_idx_t;
  typedef logic [BURST_CNT_WIDTH-1:0] burst_cnt_t;

  // Length of a full burst in awlen format
  localparam beat_idx_t FULL_LEN = beat_idx_t'(MAX_BURST_BEATS - 1);

  // Plan of one transfer, shared by all channels
  typedef struct packed {
    addr_t      base_addr;   // Burst-aligned start
    burst_cnt_t last_burst;  // Full bursts after the first one
    beat_idx_t  final_len;   // Length minus one of the last burst
    strb_t      final_strb;  // Byte mask of the very last beat
  } xfer_plan_t;

  // One address request
  typedef struct packed {
    addr_t     addr;
    beat_idx_t len;
  } aw_req_t;

  // Data channel FSM
  typedef enum logic {
    W_IDLE,
    W_RUN
  } w_state_t;

endpackage

// ==== design/wm_cmd_setup.sv ====
// Command register stage and transfer plan calculation
`timescale 1ns/10ps

module wm_cmd_setup (
  input  logic               aclk,
  input  logic               areset,
  input  logic               ctrl_start,
  input  wm_pkg::addr_t      ctrl_addr,
  input  wm_pkg::xfer_t      ctrl_size,
  input  logic               xfer_done,
  output logic               busy,
  output logic               plan_load,
  output wm_pkg::xfer_plan_t plan
);

  logic                                 accept;
  logic                                 stage1_vld;
  wm_pkg::addr_t                        addr_q;
  wm_pkg::xfer_t                        size_q;
  logic [wm_pkg::LOG_STRB-1:0]          rem;
  logic [wm_pkg::BEAT_CNT_WIDTH-1:0]    whole_beats;
  logic [wm_pkg::BEAT_CNT_WIDTH-1:0]    beats_m1;
  wm_pkg::xfer_plan_t                   plan_next;

  // Starts during a transfer are dropped
  assign accept = ctrl_start & ~busy;

  ////////////////////////////////////////////////////////////
  // Control pipeline
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      busy       <= 1'b0;
      stage1_vld <= 1'b0;
      plan_load  <= 1'b0;
    end else begin
      stage1_vld <= accept;
      plan_load  <= stage1_vld;
      if (accept) begin
        busy <= 1'b1;
      end else if (xfer_done) begin
        busy <= 1'b0;
      end
    end
  end

  // Stage 1: capture command, align address down to a burst boundary
  always_ff @(posedge aclk) begin
    if (accept) begin
      addr_q <= ctrl_addr & ~wm_pkg::addr_t'(wm_pkg::BURST_BYTES - 1);
      size_q <= ctrl_size;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 2: plan arithmetic
  ////////////////////////////////////////////////////////////
  assign rem         = size_q[wm_pkg::LOG_STRB-1:0];
  assign whole_beats = size_q[wm_pkg::XFER_WIDTH-1:wm_pkg::LOG_STRB];
  // Beats rounded up, minus one
  assign beats_m1    = (rem == '0) ? whole_beats - 1'b1 : whole_beats;

  always_comb begin
    plan_next.base_addr  = addr_q;
    plan_next.last_burst = beats_m1[wm_pkg::BEAT_CNT_WIDTH-1:wm_pkg::LOG_BURST_BEATS];
    plan_next.final_len  = beats_m1[wm_pkg::LOG_BURST_BEATS-1:0];
    // Partial last beat keeps only the low bytes
    for (int i = 0; i < wm_pkg::STRB_WIDTH; i++) begin
      plan_next.final_strb[i] = (rem == '0) || (i < rem);
    end
  end

  always_ff @(posedge aclk) begin
    if (stage1_vld) begin
      plan <= plan_next;
    end
  end

endmodule

// ==== design/wm_data_channel.sv ====
// Write data channel with stream pass-through, beat counting, wlast, strobes and first-beat marker
`timescale 1ns/10ps

module wm_data_channel (
  input  logic               aclk,
  input  logic               areset,
  input  logic               plan_load,
  input  wm_pkg::xfer_plan_t plan,
  input  logic               s_axis_tvalid,
  output logic               s_axis_tready,
  input  wm_pkg::data_t      s_axis_tdata,
  output logic               m_axi_wvalid,
  input  logic               m_axi_wready,
  output wm_pkg::data_t      m_axi_wdata,
  output wm_pkg::strb_t      m_axi_wstrb,
  output logic               m_axi_wlast,
  output logic               first_beat
);

  wm_pkg::w_state_t   state;
  logic               running;
  logic               wxfer;
  logic               final_burst;
  wm_pkg::beat_idx_t  beat_cnt;
  wm_pkg::burst_cnt_t bursts_left;
  wm_pkg::beat_idx_t  final_len_q;
  wm_pkg::strb_t      final_strb_q;
  logic               wfirst;
  logic               first_flagged;

  ////////////////////////////////////////////////////////////
  // Stream to W pass-through, only while running
  ////////////////////////////////////////////////////////////
  assign running       = (state == wm_pkg::W_RUN);
  assign m_axi_wvalid  = running & s_axis_tvalid;
  assign s_axis_tready = running & m_axi_wready;
  assign m_axi_wdata   = s_axis_tdata;
  assign wxfer         = m_axi_wvalid & m_axi_wready;

  assign final_burst = (bursts_left == '0);
  assign m_axi_wlast = running & (beat_cnt == '0);
  // Partial strobe only on the very last beat
  assign m_axi_wstrb = (m_axi_wlast & final_burst) ? final_strb_q : '1;

  always_ff @(posedge aclk) begin
    if (areset) begin
      state <= wm_pkg::W_IDLE;
    end else begin
      case (state)
        wm_pkg::W_IDLE: if (plan_load) state <= wm_pkg::W_RUN;
        wm_pkg::W_RUN:  if (wxfer && m_axi_wlast && final_burst) state <= wm_pkg::W_IDLE;
        default:        state <= wm_pkg::W_IDLE;
      endcase
    end
  end

  // Beat and burst counters; a short plan loads the partial length at once
  always_ff @(posedge aclk) begin
    if (areset) begin
      beat_cnt    <= '0;
      bursts_left <= '0;
    end else if (plan_load) begin
      bursts_left <= plan.last_burst;
      beat_cnt    <= (plan.last_burst == '0) ? plan.final_len : wm_pkg::FULL_LEN;
    end else if (wxfer) begin
      if (beat_cnt != '0) begin
        beat_cnt <= beat_cnt - 1'b1;
      end else if (!final_burst) begin
        bursts_left <= bursts_left - 1'b1;
        beat_cnt    <= (bursts_left == wm_pkg::burst_cnt_t'(1)) ? final_len_q
                                                                 : wm_pkg::FULL_LEN;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (plan_load) begin
      final_len_q  <= plan.final_len;
      final_strb_q <= plan.final_strb;
    end
  end

  ////////////////////////////////////////////////////////////
  // First-beat marker for the address channel
  ////////////////////////////////////////////////////////////
  // wfirst marks that the next beat opens a burst
  always_ff @(posedge aclk) begin
    if (areset) begin
      wfirst        <= 1'b1;
      first_flagged <= 1'b0;
      first_beat    <= 1'b0;
    end else begin
      if (plan_load) begin
        wfirst <= 1'b1;
      end else if (wxfer) begin
        wfirst <= m_axi_wlast;
      end
      // One pulse per burst even if the beat is held
      first_beat <= m_axi_wvalid & wfirst & ~first_flagged;
      if (wxfer) begin
        first_flagged <= 1'b0;
      end else if (m_axi_wvalid && wfirst) begin
        first_flagged <= 1'b1;
      end
    end
  end

endmodule

// ==== design/wm_addr_channel.sv ====
// Write address channel issuing one request per burst once its data is on the way
`timescale 1ns/10ps

module wm_addr_channel #(
  parameter int MAX_OUTSTANDING = 32
) (
  input  logic               aclk,
  input  logic               areset,
  input  logic               plan_load,
  input  wm_pkg::xfer_plan_t plan,
  input  logic               first_beat,
  input  logic               credit_ok,
  output logic               m_axi_awvalid,
  input  logic               m_axi_awready,
  output wm_pkg::addr_t      m_axi_awaddr,
  output wm_pkg::beat_idx_t  m_axi_awlen,
  output logic               aw_issued
);

  // Pending count covers every burst of one transfer and at least the credit window
  localparam int BURST_SPAN  = $bits(wm_pkg::burst_cnt_t) + 1;
  localparam int CREDIT_SPAN = $clog2(MAX_OUTSTANDING + 1);
  localparam int PEND_WIDTH  = (BURST_SPAN > CREDIT_SPAN) ? BURST_SPAN : CREDIT_SPAN;

  logic [PEND_WIDTH-1:0] pending;
  wm_pkg::addr_t         next_addr;
  wm_pkg::burst_cnt_t    bursts_left;
  wm_pkg::beat_idx_t     final_len_q;
  wm_pkg::aw_req_t       req;

  ////////////////////////////////////////////////////////////
  // Current request
  ////////////////////////////////////////////////////////////
  // Fields change only on acceptance, so they hold while awvalid is up
  assign req.addr     = next_addr;
  assign req.len      = (bursts_left == '0) ? final_len_q : wm_pkg::FULL_LEN;
  assign m_axi_awaddr = req.addr;
  assign m_axi_awlen  = req.len;
  assign aw_issued    = m_axi_awvalid & m_axi_awready;

  // Bursts with a first beat seen but no request yet
  always_ff @(posedge aclk) begin
    if (areset) begin
      pending <= '0;
    end else begin
      case ({first_beat, aw_issued})
        2'b10:   pending <= pending + 1'b1;
        2'b01:   pending <= pending - 1'b1;
        default: pending <= pending;
      endcase
    end
  end

  // Raise after pending goes non-zero, only with a free credit
  always_ff @(posedge aclk) begin
    if (areset) begin
      m_axi_awvalid <= 1'b0;
    end else if (m_axi_awvalid) begin
      if (m_axi_awready) m_axi_awvalid <= 1'b0;
    end else if (pending != '0 && credit_ok) begin
      m_axi_awvalid <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Address stepping
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      bursts_left <= '0;
    end else if (plan_load) begin
      bursts_left <= plan.last_burst;
    end else if (aw_issued && bursts_left != '0) begin
      bursts_left <= bursts_left - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (plan_load) begin
      next_addr   <= plan.base_addr;
      final_len_q <= plan.final_len;
    end else if (aw_issued) begin
      next_addr <= next_addr + wm_pkg::addr_t'(wm_pkg::BURST_BYTES);
    end
  end

endmodule

// ==== design/wm_resp_tracker.sv ====
// Write response tracker with outstanding-burst credits and done pulse
`timescale 1ns/10ps

module wm_resp_tracker #(
  parameter int MAX_OUTSTANDING = 32
) (
  input  logic               aclk,
  input  logic               areset,
  input  logic               plan_load,
  input  wm_pkg::xfer_plan_t plan,
  input  logic               aw_issued,
  input  logic               m_axi_bvalid,
  output logic               m_axi_bready,
  output logic               credit_ok,
  output logic               ctrl_done
);

  localparam int CREDIT_WIDTH = $clog2(MAX_OUTSTANDING + 1);

  logic [CREDIT_WIDTH-1:0] credits;
  wm_pkg::burst_cnt_t      b_left;
  logic                    active;
  logic                    bxfer;
  logic                    last_resp;

  // Responses never stall
  assign m_axi_bready = 1'b1;
  assign bxfer        = m_axi_bvalid & m_axi_bready;
  assign credit_ok    = (credits != '0);
  assign last_resp    = bxfer & active & (b_left == '0);

  ////////////////////////////////////////////////////////////
  // Credits, one per outstanding burst
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      credits <= CREDIT_WIDTH'(MAX_OUTSTANDING);
    end else begin
      case ({aw_issued, bxfer})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // Response countdown and done
  always_ff @(posedge aclk) begin
    if (areset) begin
      b_left    <= '0;
      active    <= 1'b0;
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= last_resp;
      if (plan_load) begin
        b_left <= plan.last_burst;
        active <= 1'b1;
      end else if (last_resp) begin
        active <= 1'b0;
      end else if (bxfer && active) begin
        b_left <= b_left - 1'b1;
      end
    end
  end

endmodule

// ==== design/wm_write_master.sv ====
// Write master top with command setup, data and address channels and response tracker
`timescale 1ns/10ps

module wm_write_master #(
  parameter int MAX_OUTSTANDING = 32
) (
  input  logic              aclk,
  input  logic              areset,
  // Command
  input  logic              ctrl_start,
  input  wm_pkg::addr_t     ctrl_addr,
  input  wm_pkg::xfer_t     ctrl_size,
  output logic              ctrl_done,
  // Stream in
  input  logic              s_axis_tvalid,
  output logic              s_axis_tready,
  input  wm_pkg::data_t     s_axis_tdata,
  // AW
  output logic              m_axi_awvalid,
  input  logic              m_axi_awready,
  output wm_pkg::addr_t     m_axi_awaddr,
  output wm_pkg::beat_idx_t m_axi_awlen,
  // W
  output logic              m_axi_wvalid,
  input  logic              m_axi_wready,
  output wm_pkg::data_t     m_axi_wdata,
  output wm_pkg::strb_t     m_axi_wstrb,
  output logic              m_axi_wlast,
  // B
  input  logic              m_axi_bvalid,
  output logic              m_axi_bready
);

  logic               plan_load;
  wm_pkg::xfer_plan_t plan;
  logic               first_beat;
  logic               credit_ok;
  logic               aw_issued;

  wm_cmd_setup u_cmd_setup (
    .aclk      (aclk),
    .areset    (areset),
    .ctrl_start(ctrl_start),
    .ctrl_addr (ctrl_addr),
    .ctrl_size (ctrl_size),
    .xfer_done (ctrl_done),
    .busy      (),
    .plan_load (plan_load),
    .plan      (plan)
  );

  wm_data_channel u_data_channel (
    .aclk         (aclk),
    .areset       (areset),
    .plan_load    (plan_load),
    .plan         (plan),
    .s_axis_tvalid(s_axis_tvalid),
    .s_axis_tready(s_axis_tready),
    .s_axis_tdata (s_axis_tdata),
    .m_axi_wvalid (m_axi_wvalid),
    .m_axi_wready (m_axi_wready),
    .m_axi_wdata  (m_axi_wdata),
    .m_axi_wstrb  (m_axi_wstrb),
    .m_axi_wlast  (m_axi_wlast),
    .first_beat   (first_beat)
  );

  wm_addr_channel #(
    .MAX_OUTSTANDING(MAX_OUTSTANDING)
  ) u_addr_channel (
    .aclk         (aclk),
    .areset       (areset),
    .plan_load    (plan_load),
    .plan         (plan),
    .first_beat   (first_beat),
    .credit_ok    (credit_ok),
    .m_axi_awvalid(m_axi_awvalid),
    .m_axi_awready(m_axi_awready),
    .m_axi_awaddr (m_axi_awaddr),
    .m_axi_awlen  (m_axi_awlen),
    .aw_issued    (aw_issued)
  );

  wm_resp_tracker #(
    .MAX_OUTSTANDING(MAX_OUTSTANDING)
  ) u_resp_tracker (
    .aclk        (aclk),
    .areset      (areset),
    .plan_load   (plan_load),
    .plan        (plan),
    .aw_issued   (aw_issued),
    .m_axi_bvalid(m_axi_bvalid),
    .m_axi_bready(m_axi_bready),
    .credit_ok   (credit_ok),
    .ctrl_done   (ctrl_done)
  );

endmodule

// ==== verification/wm_slave_model.sv ====
// Bus slave model with request and beat capture and held-off write responses
`timescale 1ns/10ps

module wm_slave_model (
  input  logic              aclk,
  input  logic              areset,
  input  logic              hold_b,
  // AW, ready comes from the testbench
  input  logic              awvalid,
  input  logic              awready,
  input  wm_pkg::addr_t     awaddr,
  input  wm_pkg::beat_idx_t awlen,
  // W, ready comes from the testbench
  input  logic              wvalid,
  input  logic              wready,
  input  wm_pkg::data_t     wdata,
  input  wm_pkg::strb_t     wstrb,
  input  logic              wlast,
  // B
  output logic              bvalid,
  input  logic              bready,
  // Captured traffic, one cycle after each handshake
  output logic              aw_seen,
  output wm_pkg::aw_req_t   aw_cap,
  output logic              w_seen,
  output wm_pkg::data_t     w_data,
  output wm_pkg::strb_t     w_strb,
  output logic              w_last,
  output logic              b_seen,
  output int                outstanding
);

  int aw_cnt;
  int wl_cnt;
  int b_cnt;
  int ready_bursts;

  // Bursts with both the request and the last beat are owed a response
  assign ready_bursts = (aw_cnt < wl_cnt) ? aw_cnt : wl_cnt;
  assign outstanding  = aw_cnt - b_cnt;

  initial bvalid = 1'b0;

  ////////////////////////////////////////////////////////////
  // Capture
  ////////////////////////////////////////////////////////////
  always @(posedge aclk) begin
    if (areset) begin
      aw_seen <= 1'b0;
      w_seen  <= 1'b0;
      b_seen  <= 1'b0;
      aw_cnt  <= 0;
      wl_cnt  <= 0;
      b_cnt   <= 0;
    end else begin
      aw_seen <= awvalid & awready;
      w_seen  <= wvalid & wready;
      b_seen  <= bvalid & bready;
      if (awvalid && awready) begin
        aw_cap.addr <= awaddr;
        aw_cap.len  <= awlen;
        aw_cnt      <= aw_cnt + 1;
      end
      if (wvalid && wready) begin
        w_data <= wdata;
        w_strb <= wstrb;
        w_last <= wlast;
        // Burst end as the slave sees it
        if (wlast) wl_cnt <= wl_cnt + 1;
      end
      if (bvalid && bready) b_cnt <= b_cnt + 1;
    end
  end

  // Responses change on the falling edge like every other master input
  always @(negedge aclk) begin
    if (areset) begin
      bvalid <= 1'b0;
    end else begin
      bvalid <= !hold_b && (ready_bursts > b_cnt);
    end
  end

endmodule

// ==== verification/tb_wm_write_master.sv ====
// Testbench top with clock, reset, stimulus driver, reference plan and compare process
`timescale 1ns/10ps

module tb_wm_write_master;

  localparam int OUTSTANDING = 2;
  localparam int TIMEOUT     = 20000;

  logic              aclk = 1'b0;
  logic              areset;
  logic              ctrl_start;
  wm_pkg::addr_t     ctrl_addr;
  wm_pkg::xfer_t     ctrl_size;
  logic              ctrl_done;
  logic              s_axis_tvalid;
  logic              s_axis_tready;
  wm_pkg::data_t     s_axis_tdata;
  logic              m_axi_awvalid;
  logic              m_axi_awready;
  wm_pkg::addr_t     m_axi_awaddr;
  wm_pkg::beat_idx_t m_axi_awlen;
  logic              m_axi_wvalid;
  logic              m_axi_wready;
  wm_pkg::data_t     m_axi_wdata;
  wm_pkg::strb_t     m_axi_wstrb;
  logic              m_axi_wlast;
  logic              m_axi_bvalid;
  logic              m_axi_bready;

  // Slave side captures
  logic              hold_b;
  logic              aw_seen;
  wm_pkg::aw_req_t   aw_cap;
  logic              w_seen;
  wm_pkg::data_t     w_data;
  wm_pkg::strb_t     w_strb;
  logic              w_last;
  logic              b_seen;
  int                outstanding;

  // Expected transfer, filled by ref_plan
  wm_pkg::addr_t     exp_addr[$];
  int                exp_len[$];
  wm_pkg::strb_t     exp_strb;
  int                exp_beats;

  // Progress and results
  int                aw_idx;
  int                w_idx;
  int                b_idx;
  int                done_cnt;
  int                err_cnt;
  int                check_cnt;
  int                burst_no;
  logic              e_last;
  wm_pkg::strb_t     e_strb;

  // Stimulus state
  logic [15:0]       lfsr;
  logic              stall_en;
  logic              start_req;
  logic              s_fire;
  wm_pkg::addr_t     start_addr;
  wm_pkg::xfer_t     start_size;
  wm_pkg::data_t     data_base;
  int                s_next;
  int                s_total;

  always #4 aclk = ~aclk;

  wm_write_master #(
    .MAX_OUTSTANDING(OUTSTANDING)
  ) u_wm_write_master (
    .aclk(aclk), .areset(areset),
    .ctrl_start(ctrl_start), .ctrl_addr(ctrl_addr), .ctrl_size(ctrl_size),
    .ctrl_done(ctrl_done),
    .s_axis_tvalid(s_axis_tvalid), .s_axis_tready(s_axis_tready),
    .s_axis_tdata(s_axis_tdata),
    .m_axi_awvalid(m_axi_awvalid), .m_axi_awready(m_axi_awready),
    .m_axi_awaddr(m_axi_awaddr), .m_axi_awlen(m_axi_awlen),
    .m_axi_wvalid(m_axi_wvalid), .m_axi_wready(m_axi_wready),
    .m_axi_wdata(m_axi_wdata), .m_axi_wstrb(m_axi_wstrb), .m_axi_wlast(m_axi_wlast),
    .m_axi_bvalid(m_axi_bvalid), .m_axi_bready(m_axi_bready)
  );

  wm_slave_model u_slave (
    .aclk(aclk), .areset(areset), .hold_b(hold_b),
    .awvalid(m_axi_awvalid), .awready(m_axi_awready),
    .awaddr(m_axi_awaddr), .awlen(m_axi_awlen),
    .wvalid(m_axi_wvalid), .wready(m_axi_wready), .wdata(m_axi_wdata),
    .wstrb(m_axi_wstrb), .wlast(m_axi_wlast),
    .bvalid(m_axi_bvalid), .bready(m_axi_bready),
    .aw_seen(aw_seen), .aw_cap(aw_cap),
    .w_seen(w_seen), .w_data(w_data), .w_strb(w_strb), .w_last(w_last),
    .b_seen(b_seen), .outstanding(outstanding)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  // Galois LFSR, taps 16,14,13,11; one step per random bit
  function automatic logic take_bit();
    logic out;
    out  = lfsr[0];
    lfsr = {1'b0, lfsr[15:1]} ^ (out ? 16'hB400 : 16'h0000);
    return out;
  endfunction

  function automatic void flag_value(input string name, input logic [31:0] got,
                                     input logic [31:0] exp);
    $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    err_cnt++;
  endfunction

  function automatic void flag_event(input string what);
    $display("Error at %0t: %s", $time, what);
    err_cnt++;
  endfunction

  // Expected bursts from address and byte count
  function automatic void ref_plan(input wm_pkg::addr_t addr, input wm_pkg::xfer_t size);
    wm_pkg::addr_t aligned;
    int            left;
    int            rem;
    aligned   = addr - (addr % wm_pkg::addr_t'(wm_pkg::BURST_BYTES));
    exp_beats = (int'(size) + wm_pkg::STRB_WIDTH - 1) / wm_pkg::STRB_WIDTH;
    rem       = int'(size) % wm_pkg::STRB_WIDTH;
    exp_addr.delete();
    exp_len.delete();
    left = exp_beats;
    while (left > 0) begin
      exp_addr.push_back(aligned + wm_pkg::addr_t'(exp_addr.size() * wm_pkg::BURST_BYTES));
      exp_len.push_back(((left > wm_pkg::MAX_BURST_BEATS) ? wm_pkg::MAX_BURST_BEATS : left) - 1);
      left = left - wm_pkg::MAX_BURST_BEATS;
    end
    // Only the low bytes of a partial last beat are written
    exp_strb = (rem == 0) ? '1 : wm_pkg::strb_t'((1 << rem) - 1);
  endfunction

  task automatic finish_run();
    $display("Checks: %0d  Errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  task automatic timeout_fail(input string what);
    flag_event({"timeout waiting for ", what});
    finish_run();
  endtask

  ////////////////////////////////////////////////////////////
  // Input driver, falling edge
  ////////////////////////////////////////////////////////////
  always @(posedge aclk) s_fire <= s_axis_tvalid & s_axis_tready;

  always @(negedge aclk) begin
    if (start_req) begin
      ctrl_start = 1'b1;
      ctrl_addr  = start_addr;
      ctrl_size  = start_size;
      start_req  = 1'b0;
    end else begin
      ctrl_start = 1'b0;
    end
    // A presented beat stays until it is taken or nothing is left to send
    if (s_axis_tvalid && s_fire) s_next = s_next + 1;
    if (!s_axis_tvalid || s_fire || s_next >= s_total) begin
      if (s_next < s_total && (!stall_en || take_bit())) begin
        s_axis_tvalid = 1'b1;
        s_axis_tdata  = data_base + wm_pkg::data_t'(s_next);
      end else begin
        s_axis_tvalid = 1'b0;
      end
    end
    m_axi_awready = !stall_en || take_bit();
    m_axi_wready  = !stall_en || take_bit();
  end

  ////////////////////////////////////////////////////////////
  // Compare process, reads captures after each rising edge
  ////////////////////////////////////////////////////////////
  always @(negedge aclk) begin
    if (!areset) begin
      if (aw_seen) begin
        check_cnt++;
        if (aw_idx >= exp_addr.size()) begin
          flag_event("address request beyond the expected burst count");
        end else begin
          if (aw_cap.addr !== exp_addr[aw_idx])
            flag_value("m_axi_awaddr", aw_cap.addr, exp_addr[aw_idx]);
          if (aw_cap.len !== wm_pkg::beat_idx_t'(exp_len[aw_idx]))
            flag_value("m_axi_awlen", 32'(aw_cap.len), 32'(exp_len[aw_idx]));
        end
        aw_idx++;
      end
      if (w_seen) begin
        check_cnt++;
        if (w_idx >= exp_beats) begin
          flag_event("write beat beyond the expected beat count");
        end else begin
          burst_no = w_idx / wm_pkg::MAX_BURST_BEATS;
          e_last   = ((w_idx % wm_pkg::MAX_BURST_BEATS) == exp_len[burst_no]);
          e_strb   = (w_idx == exp_beats - 1) ? exp_strb : '1;
          if (w_data !== data_base + wm_pkg::data_t'(w_idx))
            flag_value("m_axi_wdata", w_data, data_base + wm_pkg::data_t'(w_idx));
          if (w_last !== e_last)
            flag_value("m_axi_wlast", 32'(w_last), 32'(e_last));
          if (w_strb !== e_strb)
            flag_value("m_axi_wstrb", 32'(w_strb), 32'(e_strb));
        end
        w_idx++;
      end
      if (b_seen) b_idx++;
      // Done follows the last response by one cycle
      if (ctrl_done !== (b_seen && b_idx == exp_addr.size()))
        flag_value("ctrl_done", 32'(ctrl_done), 32'(b_seen && b_idx == exp_addr.size()));
      if (ctrl_done) done_cnt++;
      if (outstanding > OUTSTANDING)
        flag_event("more bursts outstanding than the limit allows");
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  task automatic check_idle(input int cycles);
    // A waiting stream beat must not reach the W channel while idle
    s_total = 1;
    repeat (cycles) begin
      @(posedge aclk);
      check_cnt++;
      if (m_axi_awvalid !== 1'b0) flag_value("m_axi_awvalid", 32'(m_axi_awvalid), 32'h0);
      if (m_axi_wvalid !== 1'b0) flag_value("m_axi_wvalid", 32'(m_axi_wvalid), 32'h0);
      if (s_axis_tready !== 1'b0) flag_value("s_axis_tready", 32'(s_axis_tready), 32'h0);
      if (ctrl_done !== 1'b0) flag_value("ctrl_done", 32'(ctrl_done), 32'h0);
    end
    s_total = 0;
  endtask

  task automatic run_transfer(input wm_pkg::addr_t addr, input wm_pkg::xfer_t size,
                              input logic stalls, input logic hold, input logic restart);
    int n;
    @(posedge aclk);
    ref_plan(addr, size);
    aw_idx    = 0;
    w_idx     = 0;
    b_idx     = 0;
    done_cnt  = 0;
    data_base = data_base + 32'h0010_0000;
    s_next    = 0;
    s_total   = exp_beats;
    stall_en  = stalls;
    hold_b    = hold;
    start_addr = addr;
    start_size = size;
    start_req  = 1'b1;
    // Second start while busy must be dropped
    if (restart) begin
      repeat (24) @(posedge aclk);
      start_addr = addr + 32'h0000_8000;
      start_size = 64;
      start_req  = 1'b1;
    end
    if (hold) begin
      n = 0;
      // Every beat passes while the last request waits for a credit
      while (w_idx < exp_beats && n < TIMEOUT) begin
        @(posedge aclk);
        n++;
      end
      if (w_idx < exp_beats) timeout_fail("write beats under response hold-off");
      repeat (64) @(posedge aclk);
      if (aw_idx != OUTSTANDING)
        flag_event("request count under hold-off differs from the credit limit");
      if (b_idx != 0) flag_event("response returned during hold-off");
      hold_b = 1'b0;
    end
    n = 0;
    while (done_cnt == 0 && n < TIMEOUT) begin
      @(posedge aclk);
      n++;
    end
    if (done_cnt == 0) timeout_fail("ctrl_done");
    repeat (16) @(posedge aclk);
    if (done_cnt != 1) flag_event("ctrl_done pulsed more than once");
    if (aw_idx != exp_addr.size()) flag_event("wrong number of address requests");
    if (w_idx != exp_beats) flag_event("wrong number of write beats");
  endtask

  initial begin
    areset        = 1'b1;
    ctrl_start    = 1'b0;
    ctrl_addr     = '0;
    ctrl_size     = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    m_axi_awready = 1'b0;
    m_axi_wready  = 1'b0;
    hold_b        = 1'b0;
    stall_en      = 1'b0;
    start_req     = 1'b0;
    s_fire        = 1'b0;
    start_addr    = '0;
    start_size    = '0;
    data_base     = 32'hA000_0000;
    s_next        = 0;
    s_total       = 0;
    lfsr          = 16'd25549;
    exp_beats     = 0;
    aw_idx        = 0;
    w_idx         = 0;
    b_idx         = 0;
    done_cnt      = 0;
    err_cnt       = 0;
    check_cnt     = 0;
    repeat (8) @(negedge aclk);
    areset = 1'b0;
    check_idle(16);
    // Single short burst at an unaligned address
    run_transfer(32'h0000_1236, 13, 1'b0, 1'b0, 1'b0);
    // Three bursts with random stalls and a start while busy
    run_transfer(32'h0002_0000, 3000, 1'b1, 1'b0, 1'b1);
    // Responses held back to hit the outstanding limit
    run_transfer(32'h0004_0A10, 3000, 1'b1, 1'b1, 1'b0);
    finish_run();
  end

endmodule

// ==== list.f ====
design/wm_pkg.sv
design/wm_cmd_setup.sv
design/wm_data_channel.sv
design/wm_addr_channel.sv
design/wm_resp_tracker.sv
design/wm_write_master.sv
verification/wm_slave_model.sv
verification/tb_wm_write_master.sv

// ==== Makefile ====
# Verilator build and run for the write master testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary -Wno-fatal
TOP       ?= tb_wm_write_master
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
